//--- filelist.f
hw/scb_pkg.sv
hw/scb_issue.sv
hw/scb_table.sv
hw/scb_raw_check.sv
hw/scb_top.sv
tests/tb_clk_gen.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- Makefile
SRCS := $(wildcard hw/*.sv tests/*.sv)

all: run

obj_dir/Vtb_top: filelist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_top -f filelist.f -o Vtb_top

run: obj_dir/Vtb_top
	./obj_dir/Vtb_top > sim.log 2>&1 || true
	cat sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- tests/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    import scb_pkg::*;

    logic           clk;
    logic           rst_n;
    dec_req_t [1:0] dec;
    op_req_t  [1:0] op;
    wb_req_t  [1:0] wb;
    dec_rsp_t [1:0] dec_rsp;
    logic     [1:0] op_stall;
    int             dec_errors;
    int             op_errors;
    logic           granted0;
    // ids granted and not yet written back
    scb_entry_t     live [$];

    tb_clk_gen clk_gen0 (.clk_o(clk), .rst_n_o(rst_n));

    scb_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec_i      (dec),
        .op_i       (op),
        .wb_i       (wb),
        .dec_o      (dec_rsp),
        .op_stall_o (op_stall)
    );

    tb_checker chk0 (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .dec_i        (dec),
        .op_i         (op),
        .wb_i         (wb),
        .dec_rsp_i    (dec_rsp),
        .op_stall_i   (op_stall),
        .dec_errors_o (dec_errors),
        .op_errors_o  (op_errors)
    );

    task automatic abort_run(string why);
        $display("timeout: %s", why);
        $display("=== FAIL ===");
        $finish;
    endtask

    // record grants at the falling edge, return just after the next rising edge
    task automatic next_cycle();
        @(negedge clk);
        granted0 = dec_rsp[0].grant != '0;
        for (int s = 0; s < 2; s++) begin
            if (dec_rsp[s].grant != '0) begin
                live.push_back(scb_entry_t'{busy: 1'b1, rd: dec[s].rd, sid: dec_rsp[s].sid});
            end
        end
        @(posedge clk);
    endtask

    task automatic put_dec(int s, exe_class_e cls, reg_idx_t rd);
        dec[s] <= '{valid: 1'b1, exe_class: cls, rd: rd, rs1: 5'd0, rs2: 5'd0};
    endtask

    task automatic retire(int s, int k);
        wb[s] <= '{valid: 1'b1, sid: live[k].sid, rd: live[k].rd};
        live.delete(k);
    endtask

    // small register set so hazards come often
    function automatic reg_idx_t pick_reg();
        return reg_idx_t'($urandom_range(5));
    endfunction

    function automatic sid_t pick_sid();
        if (live.size() != 0 && $urandom_range(3) != 0) begin
            return live[$urandom_range(live.size() - 1)].sid;
        end
        return sid_t'($urandom);
    endfunction

    task automatic drive_random();
        for (int s = 0; s < 2; s++) begin
            dec[s] <= '{valid: $urandom_range(3) != 0,
                        exe_class: exe_class_e'(2'($urandom_range(2))),
                        rd: pick_reg(), rs1: pick_reg(), rs2: pick_reg()};
            op[s] <= '{valid: $urandom_range(1) != 0, sid: pick_sid(),
                       rd: pick_reg(), rs1: pick_reg(), rs2: pick_reg()};
            if (live.size() != 0 && $urandom_range(2) == 0) begin
                retire(s, $urandom_range(live.size() - 1));
            end else begin
                wb[s] <= '0;
            end
        end
    endtask

    task automatic hold_until_granted(exe_class_e cls, reg_idx_t rd);
        int n;
        put_dec(0, cls, rd);
        n = 0;
        granted0 = 1'b0;
        while (!granted0 && n < 20) begin
            next_cycle();
            n++;
        end
        if (!granted0) begin
            abort_run("held decode request was never granted");
        end
        dec <= '0;
    endtask

    initial begin
        int n;
        void'($urandom(32'h396e_cada));
        dec = '0;
        op  = '0;
        wb  = '0;
        n   = 0;
        while (rst_n !== 1'b1 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            abort_run("reset was never released");
        end
        repeat (3) next_cycle();

        put_dec(0, EXE_ALU, 5'd1);
        put_dec(1, EXE_ALU, 5'd2);
        next_cycle();
        // both ALUs busy now
        put_dec(0, EXE_ALU, 5'd3);
        dec[1] <= '0;
        next_cycle();
        put_dec(0, EXE_BEU, 5'd1);
        put_dec(1, EXE_LSU, 5'd4);
        next_cycle();
        put_dec(0, EXE_BEU, 5'd6);
        put_dec(1, EXE_LSU, 5'd6);
        next_cycle();
        dec[0] <= '0;
        put_dec(1, EXE_LSU, 5'd4);
        next_cycle();

        // reader of rd 1 across the release of alu0
        dec   <= '0;
        op[0] <= '{valid: 1'b1, sid: live[0].sid + sid_t'(1), rd: 5'd9, rs1: 5'd1, rs2: 5'd0};
        next_cycle();
        retire(0, 0);
        next_cycle();
        wb <= '0;
        next_cycle();
        op <= '0;
        hold_until_granted(EXE_ALU, 5'd7);

        while (live.size() != 0) begin
            retire(0, 0);
            next_cycle();
        end
        wb <= '0;

        for (int i = 0; i < 3000; i++) begin
            drive_random();
            next_cycle();
        end
        dec <= '0;
        op  <= '0;
        wb  <= '0;
        next_cycle();

        $display("errors: dec_o %0d, op_stall_o %0d", dec_errors, op_errors);
        if (dec_errors == 0 && op_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- tests/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  scb_pkg::dec_req_t [1:0]     dec_i,
    input  scb_pkg::op_req_t  [1:0]     op_i,
    input  scb_pkg::wb_req_t  [1:0]     wb_i,
    input  scb_pkg::dec_rsp_t [1:0]     dec_rsp_i,
    input  logic              [1:0]     op_stall_i,
    output int                          dec_errors_o,
    output int                          op_errors_o
);

    import scb_pkg::*;

    typedef struct packed {
        dec_rsp_t [1:0] dec;
        logic     [1:0] op_stall;
    } expect_t;

    scb_entry_t [NUM_UNITS-1:0] model_ent;
    sid_t                       model_cnt;
    expect_t                    exp_now;

    // younger when the distance a - b falls in the lower half of the id ring
    function automatic logic is_younger(sid_t a, sid_t b);
        sid_t diff;
        diff = a - b;
        return diff != '0 && !diff[SID_W];
    endfunction

    function automatic unit_mask_t choose_unit(exe_class_e cls, unit_mask_t taken);
        unit_mask_t m;
        m = '0;
        case (cls)
            EXE_ALU: begin
                if (!taken[UNIT_ALU0]) begin
                    m[UNIT_ALU0] = 1'b1;
                end else if (!taken[UNIT_ALU1]) begin
                    m[UNIT_ALU1] = 1'b1;
                end
            end
            EXE_BEU: m[UNIT_BEU] = !taken[UNIT_BEU];
            EXE_LSU: m[UNIT_LSU] = !taken[UNIT_LSU];
            default: m = '0;
        endcase
        return m;
    endfunction

    function automatic expect_t ref_outputs(scb_entry_t [NUM_UNITS-1:0] ent, sid_t cnt,
                                            dec_req_t [1:0] dec, op_req_t [1:0] op);
        expect_t    e;
        unit_mask_t busy;
        unit_mask_t cand0;
        unit_mask_t cand1;
        logic [1:0] waw;
        logic       hit;
        e   = '0;
        waw = '0;
        for (int u = 0; u < NUM_UNITS; u++) begin
            busy[u] = ent[u].busy;
            for (int s = 0; s < 2; s++) begin
                if (ent[u].busy && ent[u].rd == dec[s].rd) begin
                    waw[s] = 1'b1;
                end
            end
        end
        cand0 = choose_unit(dec[0].exe_class, busy);
        e.dec[0].stall = dec[0].valid && (cand0 == '0 || waw[0]);
        if (dec[0].valid && !e.dec[0].stall) begin
            e.dec[0].grant = cand0;
        end
        cand1 = choose_unit(dec[1].exe_class, busy | e.dec[0].grant);
        e.dec[1].stall = dec[1].valid && (cand1 == '0 || waw[1] || e.dec[0].stall ||
                         (dec[0].valid && dec[0].rd == dec[1].rd));
        if (dec[1].valid && !e.dec[1].stall) begin
            e.dec[1].grant = cand1;
        end
        e.dec[0].sid = cnt;
        e.dec[1].sid = cnt + sid_t'(1);
        for (int s = 0; s < 2; s++) begin
            hit = 1'b0;
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (ent[u].busy && (ent[u].rd == op[s].rs1 || ent[u].rd == op[s].rs2) &&
                    is_younger(op[s].sid, ent[u].sid)) begin
                    hit = 1'b1;
                end
            end
            if (op[1-s].valid && (op[1-s].rd == op[s].rs1 || op[1-s].rd == op[s].rs2) &&
                is_younger(op[s].sid, op[1-s].sid)) begin
                hit = 1'b1;
            end
            e.op_stall[s] = op[s].valid && hit;
        end
        return e;
    endfunction

    function automatic bit mismatch(string name, logic [7:0] exp_v, logic [7:0] got_v);
        if (exp_v !== got_v) begin
            $display("FAILED %s expected 0x%h got 0x%h at %0t", name, exp_v, got_v, $time);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // grant first, then release by writeback sid
    task automatic advance_model();
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (exp_now.dec[0].grant[u]) begin
                model_ent[u] = '{busy: 1'b1, rd: dec_i[0].rd, sid: exp_now.dec[0].sid};
            end else if (exp_now.dec[1].grant[u]) begin
                model_ent[u] = '{busy: 1'b1, rd: dec_i[1].rd, sid: exp_now.dec[1].sid};
            end else if (model_ent[u].busy &&
                         ((wb_i[0].valid && wb_i[0].sid == model_ent[u].sid) ||
                          (wb_i[1].valid && wb_i[1].sid == model_ent[u].sid))) begin
                model_ent[u].busy = 1'b0;
            end
        end
        if (exp_now.dec[0].grant != '0 || exp_now.dec[1].grant != '0) begin
            model_cnt = model_cnt + sid_t'(2);
        end
    endtask

    // inputs change after the rising edge, so the falling edge sees settled outputs
    always @(negedge clk_i) begin
        if (rst_n_i !== 1'b1) begin
            model_ent    = '0;
            model_cnt    = '0;
            dec_errors_o = 0;
            op_errors_o  = 0;
        end else begin
            exp_now = ref_outputs(model_ent, model_cnt, dec_i, op_i);
            for (int s = 0; s < 2; s++) begin
                if (mismatch($sformatf("dec_o[%0d].stall", s),
                             8'(exp_now.dec[s].stall), 8'(dec_rsp_i[s].stall))) begin
                    dec_errors_o++;
                end
                if (mismatch($sformatf("dec_o[%0d].sid", s),
                             8'(exp_now.dec[s].sid), 8'(dec_rsp_i[s].sid))) begin
                    dec_errors_o++;
                end
                if (mismatch($sformatf("dec_o[%0d].grant", s),
                             8'(exp_now.dec[s].grant), 8'(dec_rsp_i[s].grant))) begin
                    dec_errors_o++;
                end
                if (mismatch($sformatf("op_stall_o[%0d]", s),
                             8'(exp_now.op_stall[s]), 8'(op_stall_i[s]))) begin
                    op_errors_o++;
                end
            end
            advance_model();
        end
    end

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- hw/scb_top.sv
`timescale 1ns/1ps

module scb_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  scb_pkg::dec_req_t [1:0]     dec_i,
    input  scb_pkg::op_req_t  [1:0]     op_i,
    input  scb_pkg::wb_req_t  [1:0]     wb_i,
    output scb_pkg::dec_rsp_t [1:0]     dec_o,
    output logic              [1:0]     op_stall_o
);

    import scb_pkg::*;

    scb_entry_t [NUM_UNITS-1:0] entries;
    unit_mask_t [1:0]           grant;
    sid_t       [1:0]           sid;

    scb_issue u_issue (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec_i     (dec_i),
        .entries_i (entries),
        .dec_o     (dec_o),
        .grant_o   (grant),
        .sid_o     (sid)
    );

    scb_table u_table (
        .clk       (clk),
        .rst_n     (rst_n),
        .grant_i   (grant),
        .sid_i     (sid),
        .dec_i     (dec_i),
        .wb_i      (wb_i),
        .entries_o (entries)
    );

    // operand stage sees the registered entries
    scb_raw_check u_raw_check (
        .op_i       (op_i),
        .entries_i  (entries),
        .op_stall_o (op_stall_o)
    );

endmodule

//--- hw/scb_raw_check.sv
`timescale 1ns/1ps

module scb_raw_check (
    input  scb_pkg::op_req_t    [1:0]                       op_i,
    input  scb_pkg::scb_entry_t [scb_pkg::NUM_UNITS-1:0]    entries_i,
    output logic                [1:0]                       op_stall_o
);

    import scb_pkg::*;

    logic [1:0] hit_entry;
    logic [1:0] hit_peer;

    // older busy producers of rs1 or rs2
    always_comb begin
        hit_entry = '0;
        for (int s = 0; s < 2; s++) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (entries_i[u].busy &&
                    (entries_i[u].rd == op_i[s].rs1 || entries_i[u].rd == op_i[s].rs2) &&
                    sid_newer(op_i[s].sid, entries_i[u].sid)) begin
                    hit_entry[s] = 1'b1;
                end
            end
        end
    end

    // producer in the other operand slot, only when that one is older
    always_comb begin
        for (int s = 0; s < 2; s++) begin
            hit_peer[s] = op_i[1-s].valid &&
                          (op_i[1-s].rd == op_i[s].rs1 || op_i[1-s].rd == op_i[s].rs2) &&
                          sid_newer(op_i[s].sid, op_i[1-s].sid);
        end
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            op_stall_o[s] = op_i[s].valid && (hit_entry[s] || hit_peer[s]);
        end
    end

endmodule

//--- hw/scb_table.sv
`timescale 1ns/1ps

module scb_table (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  scb_pkg::unit_mask_t [1:0]                       grant_i,
    input  scb_pkg::sid_t       [1:0]                       sid_i,
    input  scb_pkg::dec_req_t   [1:0]                       dec_i,
    input  scb_pkg::wb_req_t    [1:0]                       wb_i,
    output scb_pkg::scb_entry_t [scb_pkg::NUM_UNITS-1:0]    entries_o
);

    import scb_pkg::*;

    logic [NUM_UNITS-1:0] busy_q;
    reg_idx_t             rd_q  [NUM_UNITS];
    sid_t                 sid_q [NUM_UNITS];
    unit_mask_t           release_hit;

    // writeback frees the entry holding its sid
    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            release_hit[u] = busy_q[u] &&
                             ((wb_i[0].valid && wb_i[0].sid == sid_q[u]) ||
                              (wb_i[1].valid && wb_i[1].sid == sid_q[u]));
        end
    end

    // grant wins over release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= '0;
        end else begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (grant_i[0][u] || grant_i[1][u]) begin
                    busy_q[u] <= 1'b1;
                end else if (release_hit[u]) begin
                    busy_q[u] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            if (grant_i[0][u]) begin
                rd_q[u]  <= dec_i[0].rd;
                sid_q[u] <= sid_i[0];
            end else if (grant_i[1][u]) begin
                rd_q[u]  <= dec_i[1].rd;
                sid_q[u] <= sid_i[1];
            end
        end
    end

    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            entries_o[u].busy = busy_q[u];
            entries_o[u].rd   = rd_q[u];
            entries_o[u].sid  = sid_q[u];
        end
    end

    // issue only hands out free entries
    a_grant_free: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((grant_i[0] | grant_i[1]) & busy_q) == '0
    );

    a_grant_disjoint: assert property (
        @(posedge clk) disable iff (!rst_n)
        (grant_i[0] & grant_i[1]) == '0
    );

endmodule

//--- hw/scb_issue.sv
`timescale 1ns/1ps

module scb_issue (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  scb_pkg::dec_req_t   [1:0]                       dec_i,
    input  scb_pkg::scb_entry_t [scb_pkg::NUM_UNITS-1:0]    entries_i,
    output scb_pkg::dec_rsp_t   [1:0]                       dec_o,
    output scb_pkg::unit_mask_t [1:0]                       grant_o,
    output scb_pkg::sid_t       [1:0]                       sid_o
);

    import scb_pkg::*;

    unit_mask_t free;
    unit_mask_t pick0;
    unit_mask_t pick1;
    logic [1:0] waw;
    logic       same_rd;
    logic [1:0] stall;
    sid_t       sid_q;

    // alu0 first, alu1 as fallback
    function automatic unit_mask_t pick_unit(exe_class_e cls, unit_mask_t avail);
        unit_mask_t pick;
        pick = '0;
        case (cls)
            EXE_ALU: begin
                if (avail[UNIT_ALU0]) begin
                    pick[UNIT_ALU0] = 1'b1;
                end else if (avail[UNIT_ALU1]) begin
                    pick[UNIT_ALU1] = 1'b1;
                end
            end
            EXE_BEU: begin
                pick[UNIT_BEU] = avail[UNIT_BEU];
            end
            EXE_LSU: begin
                pick[UNIT_LSU] = avail[UNIT_LSU];
            end
            default: begin
                pick = '0;
            end
        endcase
        return pick;
    endfunction

    always_comb begin
        for (int u = 0; u < NUM_UNITS; u++) begin
            free[u] = !entries_i[u].busy;
        end
    end

    // slot 1 must not take what slot 0 got
    assign pick0 = pick_unit(dec_i[0].exe_class, free);
    assign pick1 = pick_unit(dec_i[1].exe_class, free & ~grant_o[0]);

    // write-after-write against busy entries
    always_comb begin
        waw = '0;
        for (int s = 0; s < 2; s++) begin
            for (int u = 0; u < NUM_UNITS; u++) begin
                if (entries_i[u].busy && entries_i[u].rd == dec_i[s].rd) begin
                    waw[s] = 1'b1;
                end
            end
        end
    end

    assign same_rd = dec_i[0].valid && dec_i[0].rd == dec_i[1].rd;

    assign stall[0] = dec_i[0].valid && (pick0 == '0 || waw[0]);

    // in-order issue: slot 1 never passes slot 0
    assign stall[1] = dec_i[1].valid &&
                      (pick1 == '0 || waw[1] || same_rd || stall[0]);

    assign grant_o[0] = (dec_i[0].valid && !stall[0]) ? pick0 : '0;
    assign grant_o[1] = (dec_i[1].valid && !stall[1]) ? pick1 : '0;

    assign sid_o[0] = sid_q;
    assign sid_o[1] = sid_q + sid_t'(1);

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            dec_o[s].stall = stall[s];
            dec_o[s].sid   = sid_o[s];
            dec_o[s].grant = grant_o[s];
        end
    end

    // two ids are consumed per accepted cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_q <= '0;
        end else if (grant_o[0] != '0 || grant_o[1] != '0) begin
            sid_q <= sid_q + sid_t'(2);
        end
    end

    a_grant_onehot: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(grant_o[0]) && $onehot0(grant_o[1])
    );

endmodule

//--- hw/scb_pkg.sv
package scb_pkg;

    // scoreboard geometry
    localparam int NUM_UNITS = 4;

    // entry index, also the bit order of a grant mask
    localparam int UNIT_ALU0 = 0;
    localparam int UNIT_ALU1 = 1;
    localparam int UNIT_BEU  = 2;
    localparam int UNIT_LSU  = 3;

    localparam int REG_W = 5;
    localparam int SID_W = 3;

    typedef logic [REG_W-1:0] reg_idx_t;

    // top bit is the wrap bit
    typedef logic [SID_W:0] sid_t;

    typedef logic [NUM_UNITS-1:0] unit_mask_t;

    typedef enum logic [1:0] {
        EXE_ALU = 2'd0,
        EXE_BEU = 2'd1,
        EXE_LSU = 2'd2
    } exe_class_e;

    // one decode slot
    typedef struct packed {
        logic       valid;
        exe_class_e exe_class;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
    } dec_req_t;

    typedef struct packed {
        logic       stall;
        sid_t       sid;
        unit_mask_t grant;
    } dec_rsp_t;

    // one operand-read slot
    typedef struct packed {
        logic     valid;
        sid_t     sid;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } op_req_t;

    typedef struct packed {
        logic     valid;
        sid_t     sid;
        reg_idx_t rd;
    } wb_req_t;

    typedef struct packed {
        logic     busy;
        reg_idx_t rd;
        sid_t     sid;
    } scb_entry_t;

    // true when a is younger than b
    function automatic logic sid_newer(sid_t a, sid_t b);
        if (a[SID_W] == b[SID_W]) begin
            return a[SID_W-1:0] > b[SID_W-1:0];
        end
        return a[SID_W-1:0] < b[SID_W-1:0];
    endfunction

endpackage
